/* spmv_defines.svh */
`ifndef SPMV_DEFINES_SVH
`define SPMV_DEFINES_SVH

// lanes per chunk, also the dense vector length
// must be a power of two
`define SPMV_N 8

// data word width, all arithmetic wraps here
`define SPMV_W 8

// column index width and number of scan levels
`define SPMV_LG_N ($clog2(`SPMV_N))

// product stage + scan levels + merge stage
`define SPMV_LATENCY (`SPMV_LG_N + 2)

`endif

/* spmv_pkg.sv */
`include "spmv_defines.svh"

package spmv_pkg;

    // one data word
    typedef logic [`SPMV_W-1:0] data_t;

    // column index into the dense vector
    typedef logic [`SPMV_LG_N-1:0] col_t;

    // one word per lane, lane 0 in the low bits
    typedef data_t [`SPMV_N-1:0] data_vec_t;

    // one column index per lane
    typedef col_t [`SPMV_N-1:0] col_vec_t;

    // one flag per lane, row ends and segment heads
    typedef logic [`SPMV_N-1:0] flag_vec_t;

endpackage

/* scan_bus.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

interface scan_bus
    import spmv_pkg::*;
();
    // chunk present on this link
    logic valid;

    // running segment sums, one per lane
    data_vec_t sum;

    // lanes whose sum already starts at a row segment head
    flag_vec_t head;

    // row end flags, carried along untouched
    flag_vec_t row_end;

    modport source (output valid, sum, head, row_end);

    modport sink (input valid, sum, head, row_end);

endinterface

/* product_stage.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module product_stage
    import spmv_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      rhs_load,
    input  data_vec_t rhs_data,
    input  logic      lhs_valid,
    input  data_vec_t lhs_data,
    input  col_vec_t  lhs_col,
    input  flag_vec_t lhs_row_end,
    scan_bus.source   out
);
    localparam int N = `SPMV_N;

    data_vec_t vec;
    data_vec_t gathered;
    flag_vec_t head_in;

    // dense vector buffer, a chunk on the load edge still sees the old vector
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            vec <= '0;
        end else if (rhs_load) begin
            vec <= rhs_data;
        end
    end

    // gather the vector element selected by each lane's column
    always_comb begin
        for (int i = 0; i < N; i++) begin
            gathered[i] = vec[lhs_col[i]];
        end
    end

    // lane 0 always opens a segment
    // any other lane opens one when the lane below closed a row
    assign head_in = {lhs_row_end[N-2:0], 1'b1};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= lhs_valid;
        end
    end

    // products wrap at the data width
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            out.sum[i] <= lhs_data[i] * gathered[i];
        end
        out.head    <= head_in;
        out.row_end <= lhs_row_end;
    end

endmodule

/* scan_level.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module scan_level
    import spmv_pkg::*;
#(
    parameter int DIST = 1
) (
    input  logic    clock,
    input  logic    reset_n,
    scan_bus.sink   prev,
    scan_bus.source next
);
    localparam int N = `SPMV_N;

    data_vec_t lower_sum;
    flag_vec_t lower_head;
    data_vec_t sum_nxt;
    flag_vec_t head_nxt;

    // lane i sees lane i - DIST, zeros shift in below DIST
    assign lower_sum  = prev.sum << (DIST * `SPMV_W);
    assign lower_head = prev.head << DIST;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (i >= DIST) begin
                // a head lane already holds its whole segment so far
                if (prev.head[i]) begin
                    sum_nxt[i] = prev.sum[i];
                end else begin
                    sum_nxt[i] = prev.sum[i] + lower_sum[i];
                end
                head_nxt[i] = prev.head[i] | lower_head[i];
            end else begin
                sum_nxt[i]  = prev.sum[i];
                head_nxt[i] = prev.head[i];
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            next.valid <= 1'b0;
        end else begin
            next.valid <= prev.valid;
        end
    end

    always_ff @(posedge clock) begin
        next.sum     <= sum_nxt;
        next.head    <= head_nxt;
        next.row_end <= prev.row_end;
    end

endmodule

/* row_merge_stage.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module row_merge_stage
    import spmv_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    scan_bus.sink     prev,
    output logic      out_valid,
    output data_vec_t out_sum,
    output flag_vec_t out_mask
);
    localparam int N = `SPMV_N;

    data_t     carry;
    data_t     carry_next;
    flag_vec_t first_end;
    data_vec_t merged;

    // lowest set row end, where a row left open by earlier chunks closes
    assign first_end = prev.row_end & (~prev.row_end + flag_vec_t'(1));

    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (!prev.row_end[i]) begin
                merged[i] = '0;
            end else if (first_end[i]) begin
                merged[i] = prev.sum[i] + carry;
            end else begin
                merged[i] = prev.sum[i];
            end
        end
    end

    // lane N-1 holds the sum of the segment still open at the chunk end
    always_comb begin
        if (prev.row_end[N-1]) begin
            carry_next = '0;
        end else if (|prev.row_end) begin
            carry_next = prev.sum[N-1];
        end else begin
            // no row closed, the whole chunk extends the open row
            carry_next = carry + prev.sum[N-1];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            carry     <= '0;
            out_valid <= 1'b0;
            out_sum   <= '0;
            out_mask  <= '0;
        end else begin
            out_valid <= prev.valid;
            if (prev.valid) begin
                carry    <= carry_next;
                out_sum  <= merged;
                out_mask <= prev.row_end;
            end
        end
    end

endmodule

/* spmv_top.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module spmv_top
    import spmv_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      rhs_load,
    input  data_vec_t rhs_data,
    input  logic      lhs_valid,
    input  data_vec_t lhs_data,
    input  col_vec_t  lhs_col,
    input  flag_vec_t lhs_row_end,
    output logic      out_valid,
    output data_vec_t out_sum,
    output flag_vec_t out_mask
);
    localparam int LG_N = `SPMV_LG_N;

    // bus[0] leaves the product stage, bus[LG_N] enters the merge stage
    scan_bus bus [LG_N+1] ();

    product_stage u_product (
        .clock       (clock),
        .reset_n     (reset_n),
        .rhs_load    (rhs_load),
        .rhs_data    (rhs_data),
        .lhs_valid   (lhs_valid),
        .lhs_data    (lhs_data),
        .lhs_col     (lhs_col),
        .lhs_row_end (lhs_row_end),
        .out         (bus[0])
    );

    // distances 1, 2, 4 up to N/2
    for (genvar g = 0; g < LG_N; g++) begin : g_scan
        scan_level #(
            .DIST (1 << g)
        ) u_level (
            .clock   (clock),
            .reset_n (reset_n),
            .prev    (bus[g]),
            .next    (bus[g+1])
        );
    end

    row_merge_stage u_merge (
        .clock     (clock),
        .reset_n   (reset_n),
        .prev      (bus[LG_N]),
        .out_valid (out_valid),
        .out_sum   (out_sum),
        .out_mask  (out_mask)
    );

endmodule

/* spmv_checker.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module spmv_checker
    import spmv_pkg::*;
(
    input logic      clock,
    input logic      reset_n,
    input logic      lhs_valid,
    input logic      out_valid,
    input data_vec_t out_sum,
    input flag_vec_t out_mask
);
    localparam int N   = `SPMV_N;
    localparam int LAT = `SPMV_LATENCY;

    a_idle_in_reset: assert property (@(posedge clock) !reset_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // fixed depth pipeline, no stalls
    a_fixed_latency: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid == $past(lhs_valid, LAT))
        else $error("out_valid does not follow lhs_valid by the pipeline depth");

    for (genvar i = 0; i < N; i++) begin : g_lane
        a_masked_zero: assert property (@(posedge clock) disable iff (!reset_n)
            !out_mask[i] |-> out_sum[i] == '0)
            else $error("lane %0d has a nonzero sum but no row end", i);
    end

endmodule

bind spmv_top spmv_checker u_checker (
    .clock     (clock),
    .reset_n   (reset_n),
    .lhs_valid (lhs_valid),
    .out_valid (out_valid),
    .out_sum   (out_sum),
    .out_mask  (out_mask)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset_n
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

/* spmv_tb.sv */
`timescale 1ns/1ps
`include "spmv_defines.svh"

module spmv_tb
    import spmv_pkg::*;
();
    localparam int N             = `SPMV_N;
    localparam int LAT           = `SPMV_LATENCY;
    localparam int RESET_CYCLES  = 4;
    localparam int RANDOM_CHUNKS = 200;
    localparam int NUM_TESTS     = 6;
    localparam int TOTAL_CHUNKS  = 1 + 4 + 4 + 6 + 6 + RANDOM_CHUNKS;
    // drain per test plus idle and vector load cycles
    localparam int GAP_CYCLES    = NUM_TESTS * (LAT + 4) + 16;
    localparam int TIMEOUT_CYCLES =
        2 * (TOTAL_CHUNKS + LAT + RESET_CYCLES + GAP_CYCLES);
    localparam flag_vec_t CROSS_ENDS [6] = '{8'h00, 8'h00, 8'h04, 8'h10, 8'h00, 8'h81};

    logic      clock;
    logic      reset_n;
    logic      rhs_load;
    data_vec_t rhs_data;
    logic      lhs_valid;
    data_vec_t lhs_data;
    col_vec_t  lhs_col;
    flag_vec_t lhs_row_end;
    logic      out_valid;
    data_vec_t out_sum;
    flag_vec_t out_mask;

    integer    seed = 32'h9a9d018d;
    int        cycle_count = 0;
    string     test_name = "none";
    int        test_errors = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;

    // model state, follows the DUT in send order
    data_vec_t model_vec = '0;
    data_t     model_carry = '0;

    data_vec_t exp_sum_q [$];
    flag_vec_t exp_mask_q [$];

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clock   (clock),
        .reset_n (reset_n)
    );

    spmv_top UUT (
        .clock       (clock),
        .reset_n     (reset_n),
        .rhs_load    (rhs_load),
        .rhs_data    (rhs_data),
        .lhs_valid   (lhs_valid),
        .lhs_data    (lhs_data),
        .lhs_col     (lhs_col),
        .lhs_row_end (lhs_row_end),
        .out_valid   (out_valid),
        .out_sum     (out_sum),
        .out_mask    (out_mask)
    );

    // walk the lanes, closing a row sum at every row end
    function automatic void model_chunk(input data_vec_t vals, input col_vec_t cols,
                                        input flag_vec_t ends, output data_vec_t sums,
                                        output flag_vec_t mask);
        data_t acc;
        acc = model_carry;
        for (int i = 0; i < N; i++) begin
            acc = acc + vals[i] * model_vec[cols[i]];
            if (ends[i]) begin
                sums[i] = acc;
                acc = '0;
            end else begin
                sums[i] = '0;
            end
        end
        mask = ends;
        model_carry = acc;
    endfunction

    function automatic data_vec_t random_data();
        data_vec_t v;
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            v[i] = r[`SPMV_W-1:0];
        end
        return v;
    endfunction

    function automatic col_vec_t random_cols();
        col_vec_t c;
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            c[i] = r[`SPMV_LG_N-1:0];
        end
        return c;
    endfunction

    function automatic flag_vec_t random_flags();
        logic [31:0] r;
        r = $random(seed);
        return r[N-1:0];
    endfunction

    task automatic check_sum(input data_vec_t expected, input data_vec_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: out_sum expected %h actual %h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_mask(input flag_vec_t expected, input flag_vec_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: out_mask expected %h actual %h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        rhs_load  = 1'b0;
        lhs_valid = 1'b0;
    endtask

    // new vector takes effect for chunks sampled after this edge
    task automatic load_vector(input data_vec_t v);
        @(negedge clock);
        rhs_load  = 1'b1;
        rhs_data  = v;
        lhs_valid = 1'b0;
        model_vec = v;
    endtask

    task automatic send_chunk(input data_vec_t vals, input col_vec_t cols,
                              input flag_vec_t ends);
        data_vec_t exp_sum;
        flag_vec_t exp_mask;
        @(negedge clock);
        rhs_load    = 1'b0;
        lhs_valid   = 1'b1;
        lhs_data    = vals;
        lhs_col     = cols;
        lhs_row_end = ends;
        model_chunk(vals, cols, ends, exp_sum, exp_mask);
        exp_sum_q.push_back(exp_sum);
        exp_mask_q.push_back(exp_mask);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_sum_q.size() != 0 && waited < LAT + 2) begin
            @(negedge clock);
            waited++;
        end
        repeat (2) idle_cycle();
        if (exp_sum_q.size() != 0) begin
            $display("%s: %0d expected results never came out", test_name, exp_sum_q.size());
            test_errors++;
            exp_sum_q.delete();
            exp_mask_q.delete();
        end
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin : compare_results
        data_vec_t exp_s;
        flag_vec_t exp_m;
        if (reset_n && out_valid) begin
            if (exp_sum_q.size() == 0) begin
                $display("%s: out_valid high with no result expected", test_name);
                test_errors++;
            end else begin
                exp_s = exp_sum_q.pop_front();
                exp_m = exp_mask_q.pop_front();
                check_sum(exp_s, out_sum);
                check_mask(exp_m, out_mask);
            end
        end
    end

    always @(posedge clock) begin
        if (cycle_count < TIMEOUT_CYCLES) begin
            cycle_count++;
        end else begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        data_vec_t fixed_data;
        col_vec_t  fixed_cols;
        rhs_load    = 1'b0;
        rhs_data    = '0;
        lhs_valid   = 1'b0;
        lhs_data    = '0;
        lhs_col     = '0;
        lhs_row_end = '0;
        wait (reset_n === 1'b1);

        // nothing may come out before a chunk goes in
        start_test("reset_state");
        repeat (8) idle_cycle();
        load_vector(random_data());
        send_chunk(random_data(), random_cols(), flag_vec_t'(8'h21));
        finish_test();

        start_test("every_lane_a_row");
        repeat (4) send_chunk(random_data(), random_cols(), '1);
        finish_test();

        start_test("one_row_per_chunk");
        repeat (4) send_chunk(random_data(), random_cols(), flag_vec_t'(1) << (N - 1));
        finish_test();

        start_test("rows_cross_chunks");
        for (int k = 0; k < 6; k++) begin
            send_chunk(random_data(), random_cols(), CROSS_ENDS[k]);
        end
        finish_test();

        // same chunks against two vectors, lane N-1 left open
        start_test("vector_reload");
        fixed_data = random_data();
        fixed_cols = random_cols();
        load_vector(random_data());
        repeat (3) send_chunk(fixed_data, fixed_cols, flag_vec_t'(8'h12));
        load_vector(random_data());
        repeat (3) send_chunk(fixed_data, fixed_cols, flag_vec_t'(8'h12));
        finish_test();

        start_test("random_stream");
        repeat (RANDOM_CHUNKS) send_chunk(random_data(), random_cols(), random_flags());
        finish_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
spmv_pkg.sv
scan_bus.sv
product_stage.sv
scan_level.sv
row_merge_stage.sv
spmv_top.sv
spmv_checker.sv
tb_clock_gen.sv
spmv_tb.sv

/* run.sh */
#!/bin/sh
# build the SpMV testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module spmv_tb -o spmv_sim &&
    ./obj_dir/spmv_sim | tee /dev/stderr | grep -qx "sim passed" &&
    exit 0 ||
    exit 1
